// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module tb_dual_execute -f build.f
	./obj_dir/Vtb_dual_execute | tee /dev/stderr | grep "all tests passed" > /dev/null

clean:
	rm -rf obj_dir

// ==== build.f ====
source/exec_pkg.sv
source/int_alu.sv
source/branch_unit.sv
source/exec_lane.sv
source/dual_execute.sv
testbench/exec_sva.sv
testbench/exec_checker.sv
testbench/tb_dual_execute.sv

// ==== source/branch_unit.sv ====
`timescale 1ns/100ps

module branch_unit (
    input  exec_pkg::alu_op_e         op_i,
    input  logic [exec_pkg::XLEN-1:0] rj_i,
    input  logic [exec_pkg::XLEN-1:0] rd_i,
    input  logic [exec_pkg::XLEN-1:0] pc_i,
    input  logic [exec_pkg::XLEN-1:0] imm_i,
    output logic                      taken_o,
    output logic [exec_pkg::XLEN-1:0] target_o,
    output logic [exec_pkg::XLEN-1:0] link_o
);

    logic eq;
    logic lt_s;
    logic lt_u;

    // rj against rd, as in the la32 branch forms
    assign eq   = rj_i == rd_i;
    assign lt_s = $signed(rj_i) < $signed(rd_i);
    assign lt_u = rj_i < rd_i;

    always_comb begin
        case (op_i)
            exec_pkg::BEQ:  taken_o = eq;
            exec_pkg::BNE:  taken_o = !eq;
            exec_pkg::BLT:  taken_o = lt_s;
            exec_pkg::BGE:  taken_o = !lt_s;
            exec_pkg::BLTU: taken_o = lt_u;
            exec_pkg::BGEU: taken_o = !lt_u;
            exec_pkg::JIRL: taken_o = 1'b1;
            default:        taken_o = 1'b0;
        endcase
    end

    // jirl is register relative, branches are pc relative
    assign target_o = (op_i == exec_pkg::JIRL) ? rj_i + imm_i : pc_i + imm_i;

    assign link_o = pc_i + 32'd4;

endmodule

// ==== source/dual_execute.sv ====
`timescale 1ns/100ps

module dual_execute (
    input  logic                                                clk,
    input  logic                                                rst_n_i,
    // dispatch
    input  logic [exec_pkg::ISSUE_WIDTH-1:0]                    ex_valid_i,
    input  exec_pkg::alu_op_e [exec_pkg::ISSUE_WIDTH-1:0]       ex_op_i,
    input  logic [exec_pkg::ISSUE_WIDTH-1:0][exec_pkg::XLEN-1:0] ex_pc_i,
    input  logic [exec_pkg::ISSUE_WIDTH-1:0][exec_pkg::XLEN-1:0] ex_src1_i,
    input  logic [exec_pkg::ISSUE_WIDTH-1:0][exec_pkg::XLEN-1:0] ex_src2_i,
    input  logic [exec_pkg::ISSUE_WIDTH-1:0][exec_pkg::XLEN-1:0] ex_imm_i,
    input  logic [exec_pkg::ISSUE_WIDTH-1:0][exec_pkg::REG_AW-1:0] ex_rd_i,
    input  logic [exec_pkg::ISSUE_WIDTH-1:0]                    ex_wen_i,
    // controller
    input  logic                                                flush_i,
    input  logic                                                pause_i,
    // data cache
    output logic                                                dc_valid_o,
    output logic                                                dc_we_o,
    output logic [exec_pkg::XLEN-1:0]                           dc_addr_o,
    output logic [exec_pkg::XLEN-1:0]                           dc_wdata_o,
    output logic [3:0]                                          dc_wstrb_o,
    input  logic                                                dc_addr_ok_i,
    output logic                                                pause_ex_o,
    output logic                                                branch_flush_o,
    output logic [exec_pkg::XLEN-1:0]                           branch_target_o,
    // forwarding
    output logic [exec_pkg::ISSUE_WIDTH-1:0]                    fwd_wen_o,
    output logic [exec_pkg::ISSUE_WIDTH-1:0][exec_pkg::REG_AW-1:0] fwd_rd_o,
    output logic [exec_pkg::ISSUE_WIDTH-1:0][exec_pkg::XLEN-1:0] fwd_data_o,
    // memory stage
    output logic [exec_pkg::ISSUE_WIDTH-1:0]                    mem_valid_o,
    output exec_pkg::alu_op_e [exec_pkg::ISSUE_WIDTH-1:0]       mem_op_o,
    output logic [exec_pkg::ISSUE_WIDTH-1:0][exec_pkg::REG_AW-1:0] mem_rd_o,
    output logic [exec_pkg::ISSUE_WIDTH-1:0]                    mem_wen_o,
    output logic [exec_pkg::ISSUE_WIDTH-1:0][exec_pkg::XLEN-1:0] mem_result_o,
    output logic [exec_pkg::ISSUE_WIDTH-1:0][exec_pkg::XLEN-1:0] mem_addr_o
);

    logic [1:0]                       req;
    logic [1:0]                       req_we;
    logic [1:0][exec_pkg::XLEN-1:0]   req_addr;
    logic [1:0][exec_pkg::XLEN-1:0]   req_wdata;
    logic [1:0][3:0]                  req_wstrb;
    logic [1:0]                       stall;
    logic [1:0]                       redirect;
    logic [1:0][exec_pkg::XLEN-1:0]   target;
    logic [1:0][exec_pkg::XLEN-1:0]   result;
    logic [1:0][exec_pkg::XLEN-1:0]   addr;
    logic [1:0]                       keep;

    exec_lane lane0 (
        .clk(clk), .rst_n_i(rst_n_i), .valid_i(ex_valid_i[0]), .op_i(ex_op_i[0]),
        .pc_i(ex_pc_i[0]), .src1_i(ex_src1_i[0]), .src2_i(ex_src2_i[0]),
        .imm_i(ex_imm_i[0]), .rd_i(ex_rd_i[0]), .wen_i(ex_wen_i[0]),
        .addr_ok_i(dc_addr_ok_i),
        .req_o(req[0]), .req_we_o(req_we[0]), .req_addr_o(req_addr[0]),
        .req_wdata_o(req_wdata[0]), .req_wstrb_o(req_wstrb[0]),
        .stall_o(stall[0]), .redirect_o(redirect[0]), .target_o(target[0]),
        .result_o(result[0]), .addr_o(addr[0])
    );

    exec_lane lane1 (
        .clk(clk), .rst_n_i(rst_n_i), .valid_i(ex_valid_i[1]), .op_i(ex_op_i[1]),
        .pc_i(ex_pc_i[1]), .src1_i(ex_src1_i[1]), .src2_i(ex_src2_i[1]),
        .imm_i(ex_imm_i[1]), .rd_i(ex_rd_i[1]), .wen_i(ex_wen_i[1]),
        .addr_ok_i(dc_addr_ok_i),
        .req_o(req[1]), .req_we_o(req_we[1]), .req_addr_o(req_addr[1]),
        .req_wdata_o(req_wdata[1]), .req_wstrb_o(req_wstrb[1]),
        .stall_o(stall[1]), .redirect_o(redirect[1]), .target_o(target[1]),
        .result_o(result[1]), .addr_o(addr[1])
    );

    // one cache port, lane 0 wins
    assign dc_valid_o = |req;
    assign dc_we_o    = req[0] ? req_we[0]    : req_we[1];
    assign dc_addr_o  = req[0] ? req_addr[0]  : req_addr[1];
    assign dc_wdata_o = req[0] ? req_wdata[0] : req_wdata[1];
    assign dc_wstrb_o = req[0] ? req_wstrb[0] : req_wstrb[1];

    assign pause_ex_o     = |stall;
    assign branch_flush_o = |redirect && !pause_ex_o;

    always_comb begin
        if (!branch_flush_o) begin
            branch_target_o = '0;
        end else if (redirect[0]) begin
            branch_target_o = target[0];
        end else begin
            branch_target_o = target[1];
        end
    end

    assign fwd_rd_o   = ex_rd_i;
    assign fwd_data_o = result;
    assign fwd_wen_o[0] = ex_valid_i[0] && ex_wen_i[0] && (ex_rd_i[0] != '0);
    assign fwd_wen_o[1] = ex_valid_i[1] && ex_wen_i[1] && (ex_rd_i[1] != '0);

    // lane 1 is younger and dies behind a lane 0 redirect
    assign keep[0] = ex_valid_i[0];
    assign keep[1] = ex_valid_i[1] && !redirect[0];

    always_ff @(posedge clk) begin
        if (!rst_n_i || flush_i || pause_ex_o) begin
            mem_valid_o  <= '0;
            mem_op_o     <= {exec_pkg::NOP, exec_pkg::NOP};
            mem_rd_o     <= '0;
            mem_wen_o    <= '0;
            mem_result_o <= '0;
            mem_addr_o   <= '0;
        end else if (!pause_i) begin
            for (int i = 0; i < exec_pkg::ISSUE_WIDTH; i++) begin
                mem_valid_o[i]  <= keep[i];
                mem_op_o[i]     <= keep[i] ? ex_op_i[i] : exec_pkg::NOP;
                mem_rd_o[i]     <= keep[i] ? ex_rd_i[i] : '0;
                mem_wen_o[i]    <= keep[i] && fwd_wen_o[i];
                mem_result_o[i] <= keep[i] ? result[i] : '0;
                mem_addr_o[i]   <= keep[i] ? addr[i] : '0;
            end
        end
    end

endmodule

// ==== source/exec_lane.sv ====
`timescale 1ns/100ps

module exec_lane (
    input  logic                        clk,
    input  logic                        rst_n_i,
    input  logic                        valid_i,
    input  exec_pkg::alu_op_e           op_i,
    input  logic [exec_pkg::XLEN-1:0]   pc_i,
    input  logic [exec_pkg::XLEN-1:0]   src1_i,
    input  logic [exec_pkg::XLEN-1:0]   src2_i,
    input  logic [exec_pkg::XLEN-1:0]   imm_i,
    input  logic [exec_pkg::REG_AW-1:0] rd_i,
    input  logic                        wen_i,
    input  logic                        addr_ok_i,
    output logic                        req_o,
    output logic                        req_we_o,
    output logic [exec_pkg::XLEN-1:0]   req_addr_o,
    output logic [exec_pkg::XLEN-1:0]   req_wdata_o,
    output logic [3:0]                  req_wstrb_o,
    output logic                        stall_o,
    output logic                        redirect_o,
    output logic [exec_pkg::XLEN-1:0]   target_o,
    output logic [exec_pkg::XLEN-1:0]   result_o,
    output logic [exec_pkg::XLEN-1:0]   addr_o
);

    logic [exec_pkg::XLEN-1:0] alu_b;
    logic [exec_pkg::XLEN-1:0] alu_res;
    logic [exec_pkg::XLEN-1:0] link;
    logic [exec_pkg::XLEN-1:0] ea;
    logic                      taken;
    logic                      mem_op;
    logic                      held;
    logic                      sent_q;
    logic [exec_pkg::XLEN-1:0] sent_pc_q;

    // lu12i takes the 20-bit immediate shifted up, the rest use src2
    assign alu_b = (op_i == exec_pkg::LU12I) ? {imm_i[19:0], 12'b0} : src2_i;

    int_alu u_alu (
        .op_i    (op_i),
        .a_i     (src1_i),
        .b_i     (alu_b),
        .result_o(alu_res)
    );

    branch_unit u_bru (
        .op_i    (op_i),
        .rj_i    (src1_i),
        .rd_i    (src2_i),
        .pc_i    (pc_i),
        .imm_i   (imm_i),
        .taken_o (taken),
        .target_o(target_o),
        .link_o  (link)
    );

    assign redirect_o = valid_i && taken;

    // writes to r0 are dropped
    always_comb begin
        if (rd_i == '0) begin
            result_o = '0;
        end else if (taken && wen_i) begin
            result_o = link;
        end else begin
            result_o = alu_res;
        end
    end

    assign ea     = src1_i + imm_i;
    assign mem_op = exec_pkg::is_mem(op_i);
    assign addr_o = mem_op ? ea : '0;

    // same instruction still sitting here after its request went out
    assign held = sent_q && valid_i && (pc_i == sent_pc_q);

    assign req_o      = valid_i && mem_op && !held;
    assign req_we_o   = exec_pkg::is_store(op_i);
    assign req_addr_o = ea;
    assign stall_o    = req_o && !addr_ok_i;

    always_comb begin
        case (op_i)
            exec_pkg::ST_W: begin
                req_wstrb_o = 4'b1111;
                req_wdata_o = src2_i;
            end
            exec_pkg::ST_B: begin
                req_wstrb_o = 4'b0001 << ea[1:0];
                req_wdata_o = {4{src2_i[7:0]}};
            end
            default: begin
                req_wstrb_o = 4'b0000;
                req_wdata_o = '0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            sent_q <= 1'b0;
        end else if (req_o && addr_ok_i) begin
            sent_q <= 1'b1;
        end else if (!held) begin
            sent_q <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (req_o && addr_ok_i) begin
            sent_pc_q <= pc_i;
        end
    end

endmodule

// ==== source/exec_pkg.sv ====
package exec_pkg;

    // datapath widths
    parameter int XLEN        = 32;
    parameter int REG_AW      = 5;
    parameter int ISSUE_WIDTH = 2;

    // lane operation, NOP must stay at zero so a cleared register reads as a bubble
    typedef enum logic [4:0] {
        NOP   = 5'd0,
        ADD   = 5'd1,
        SUB   = 5'd2,
        AND   = 5'd3,
        OR    = 5'd4,
        XOR   = 5'd5,
        SLL   = 5'd6,
        SRL   = 5'd7,
        SRA   = 5'd8,
        SLT   = 5'd9,
        SLTU  = 5'd10,
        LU12I = 5'd11,
        // conditional branches
        BEQ   = 5'd12,
        BNE   = 5'd13,
        BLT   = 5'd14,
        BGE   = 5'd15,
        BLTU  = 5'd16,
        BGEU  = 5'd17,
        // indirect jump with link
        JIRL  = 5'd18,
        // data cache access
        LD_W  = 5'd19,
        ST_W  = 5'd20,
        ST_B  = 5'd21
    } alu_op_e;

    // ops that go to the data cache
    function automatic logic is_mem(input alu_op_e op);
        logic mem;
        case (op)
            LD_W, ST_W, ST_B: mem = 1'b1;
            default:          mem = 1'b0;
        endcase
        return mem;
    endfunction

    // ops that write memory
    function automatic logic is_store(input alu_op_e op);
        logic st;
        case (op)
            ST_W, ST_B: st = 1'b1;
            default:    st = 1'b0;
        endcase
        return st;
    endfunction

endpackage

// ==== source/int_alu.sv ====
`timescale 1ns/100ps

module int_alu (
    input  exec_pkg::alu_op_e         op_i,
    input  logic [exec_pkg::XLEN-1:0] a_i,
    input  logic [exec_pkg::XLEN-1:0] b_i,
    output logic [exec_pkg::XLEN-1:0] result_o
);

    logic signed [exec_pkg::XLEN-1:0] a_s;
    logic signed [exec_pkg::XLEN-1:0] b_s;
    logic [4:0]                       shamt;
    logic                             lt_s;
    logic                             lt_u;

    assign a_s   = a_i;
    assign b_s   = b_i;
    // shift amount from the low five bits only
    assign shamt = b_i[4:0];

    assign lt_s = a_s < b_s;
    assign lt_u = a_i < b_i;

    always_comb begin
        case (op_i)
            exec_pkg::ADD: begin
                result_o = a_i + b_i;
            end
            exec_pkg::SUB: begin
                result_o = a_i - b_i;
            end
            exec_pkg::AND: begin
                result_o = a_i & b_i;
            end
            exec_pkg::OR: begin
                result_o = a_i | b_i;
            end
            exec_pkg::XOR: begin
                result_o = a_i ^ b_i;
            end
            exec_pkg::SLL: begin
                result_o = a_i << shamt;
            end
            exec_pkg::SRL: begin
                result_o = a_i >> shamt;
            end
            exec_pkg::SRA: begin
                result_o = a_s >>> shamt;
            end
            exec_pkg::SLT: begin
                result_o = {{(exec_pkg::XLEN-1){1'b0}}, lt_s};
            end
            exec_pkg::SLTU: begin
                result_o = {{(exec_pkg::XLEN-1){1'b0}}, lt_u};
            end
            exec_pkg::LU12I: begin
                // upper immediate arrives already in place
                result_o = b_i;
            end
            default: begin
                result_o = '0;
            end
        endcase
    end

endmodule

// ==== testbench/exec_checker.sv ====
`timescale 1ns/100ps

module exec_checker (
    input  logic                    clk,
    input  logic                    rst_n_i,
    input  logic [1:0]              ex_valid_i,
    input  exec_pkg::alu_op_e [1:0] ex_op_i,
    input  logic [1:0][31:0]        ex_pc_i,
    input  logic [1:0][31:0]        ex_src1_i,
    input  logic [1:0][31:0]        ex_src2_i,
    input  logic [1:0][31:0]        ex_imm_i,
    input  logic [1:0][4:0]         ex_rd_i,
    input  logic [1:0]              ex_wen_i,
    input  logic                    flush_i,
    input  logic                    pause_i,
    input  logic                    dc_valid_o,
    input  logic                    dc_we_o,
    input  logic [31:0]             dc_addr_o,
    input  logic [31:0]             dc_wdata_o,
    input  logic [3:0]              dc_wstrb_o,
    input  logic                    dc_addr_ok_i,
    input  logic                    pause_ex_o,
    input  logic                    branch_flush_o,
    input  logic [31:0]             branch_target_o,
    input  logic [1:0]              fwd_wen_o,
    input  logic [1:0][4:0]         fwd_rd_o,
    input  logic [1:0][31:0]        fwd_data_o,
    input  logic [1:0]              mem_valid_o,
    input  exec_pkg::alu_op_e [1:0] mem_op_o,
    input  logic [1:0][4:0]         mem_rd_o,
    input  logic [1:0]              mem_wen_o,
    input  logic [1:0][31:0]        mem_result_o,
    input  logic [1:0][31:0]        mem_addr_o,
    output int                      err_count_o,
    output int                      chk_count_o
);

    int          errors = 0;
    int          checks = 0;
    logic        known  = 1'b0;
    logic        tk [2];
    logic        mem [2];
    logic        fwd_on [2];
    logic [31:0] tgt [2];
    logic [31:0] res [2];
    // {we, addr, wdata, wstrb}
    logic [68:0] rq [2];
    // {valid, op, rd, wen, result, addr}
    logic [75:0] m_exp [2];
    logic        done_flag;
    logic [31:0] done_pc;
    int          ml;
    logic        held;
    logic        req_exp;
    logic        stall;
    logic        redir0;
    logic        redir1;
    logic        flush_exp;
    logic [31:0] tgt_exp;
    logic        keep;

    assign err_count_o = errors;
    assign chk_count_o = checks;

    function automatic void lane_ref(
        input  exec_pkg::alu_op_e op,
        input  logic [31:0]       pc,
        input  logic [31:0]       a,
        input  logic [31:0]       b,
        input  logic [31:0]       imm,
        input  logic [4:0]        rd,
        input  logic              wen,
        output logic              taken,
        output logic [31:0]       target,
        output logic [31:0]       result,
        output logic [68:0]       req
    );
        logic [31:0] alu;
        logic [31:0] ea;
        ea = a + imm;
        case (op)
            exec_pkg::ADD:   alu = a + b;
            exec_pkg::SUB:   alu = a - b;
            exec_pkg::AND:   alu = a & b;
            exec_pkg::OR:    alu = a | b;
            exec_pkg::XOR:   alu = a ^ b;
            exec_pkg::SLL:   alu = a << b[4:0];
            exec_pkg::SRL:   alu = a >> b[4:0];
            exec_pkg::SRA:   alu = $signed(a) >>> b[4:0];
            exec_pkg::SLT:   alu = {31'b0, $signed(a) < $signed(b)};
            exec_pkg::SLTU:  alu = {31'b0, a < b};
            exec_pkg::LU12I: alu = {imm[19:0], 12'b0};
            default:         alu = '0;
        endcase
        case (op)
            exec_pkg::BEQ:  taken = (a == b);
            exec_pkg::BNE:  taken = (a != b);
            exec_pkg::BLT:  taken = ($signed(a) < $signed(b));
            exec_pkg::BGE:  taken = ($signed(a) >= $signed(b));
            exec_pkg::BLTU: taken = (a < b);
            exec_pkg::BGEU: taken = (a >= b);
            exec_pkg::JIRL: taken = 1'b1;
            default:        taken = 1'b0;
        endcase
        target = (op == exec_pkg::JIRL) ? a + imm : pc + imm;
        // r0 never receives a value, taken branches link pc+4
        result = (rd == 5'd0) ? '0 : (taken && wen) ? pc + 32'd4 : alu;
        case (op)
            exec_pkg::LD_W: req = {1'b0, ea, 32'h0, 4'b0000};
            exec_pkg::ST_W: req = {1'b1, ea, b, 4'b1111};
            exec_pkg::ST_B: req = {1'b1, ea, {4{b[7:0]}}, 4'b0001 << ea[1:0]};
            default:        req = '0;
        endcase
    endfunction

    task automatic compare(input string name, input logic [79:0] exp, input logic [79:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("FAILED %s: expected %h, actual %h", name, exp, act);
        end
    endtask

    always @(posedge clk) begin
        // register contents left by the previous edge
        if (known) begin
            for (int i = 0; i < 2; i++) begin
                compare($sformatf("mem_register lane%0d", i), 80'(m_exp[i]),
                        80'({mem_valid_o[i], mem_op_o[i], mem_rd_o[i], mem_wen_o[i],
                             mem_result_o[i], mem_addr_o[i]}));
            end
        end
        known = 1'b1;
        if (!rst_n_i) begin
            m_exp[0]  = '0;
            m_exp[1]  = '0;
            done_flag = 1'b0;
        end else begin
            for (int i = 0; i < 2; i++) begin
                lane_ref(ex_op_i[i], ex_pc_i[i], ex_src1_i[i], ex_src2_i[i], ex_imm_i[i],
                         ex_rd_i[i], ex_wen_i[i], tk[i], tgt[i], res[i], rq[i]);
                mem[i] = ex_op_i[i] inside {exec_pkg::LD_W, exec_pkg::ST_W, exec_pkg::ST_B};
                fwd_on[i] = ex_valid_i[i] && ex_wen_i[i] && (ex_rd_i[i] != 5'd0);
                compare($sformatf("forwarding lane%0d", i),
                        80'({fwd_on[i], ex_rd_i[i], res[i]}),
                        80'({fwd_wen_o[i], fwd_rd_o[i], fwd_data_o[i]}));
            end
            // an accepted request is not sent again while the pair is held
            ml        = mem[0] ? 0 : 1;
            held      = done_flag && ex_valid_i[ml] && (ex_pc_i[ml] == done_pc);
            req_exp   = ex_valid_i[ml] && mem[ml] && !held;
            stall     = req_exp && !dc_addr_ok_i;
            redir0    = ex_valid_i[0] && tk[0];
            redir1    = ex_valid_i[1] && tk[1];
            flush_exp = (redir0 || redir1) && !stall;
            tgt_exp   = !flush_exp ? '0 : redir0 ? tgt[0] : tgt[1];
            compare("stall", 80'({req_exp, stall}), 80'({dc_valid_o, pause_ex_o}));
            compare("branch_redirect", 80'({flush_exp, tgt_exp}),
                    80'({branch_flush_o, branch_target_o}));
            if (req_exp) begin
                compare("cache_request", 80'(rq[ml]),
                        80'({dc_we_o, dc_addr_o, dc_wdata_o, dc_wstrb_o}));
            end
            if (req_exp && dc_addr_ok_i) begin
                done_flag = 1'b1;
                done_pc   = ex_pc_i[ml];
            end else if (!held) begin
                done_flag = 1'b0;
            end
            // next memory register
            if (flush_i || stall) begin
                m_exp[0] = '0;
                m_exp[1] = '0;
            end else if (!pause_i) begin
                for (int i = 0; i < 2; i++) begin
                    keep = ex_valid_i[i] && !(i == 1 && redir0);
                    m_exp[i] = keep ? {1'b1, ex_op_i[i], ex_rd_i[i], fwd_on[i], res[i],
                                       rq[i][67:36]} : '0;
                end
            end
        end
    end

endmodule

// ==== testbench/exec_sva.sv ====
`timescale 1ns/100ps

module exec_sva (
    input logic                    clk,
    input logic                    rst_n_i,
    input logic [1:0]              ex_valid_i,
    input exec_pkg::alu_op_e [1:0] ex_op_i,
    input logic                    pause_i,
    input logic                    pause_ex_i,
    input logic                    dc_valid_i,
    input logic [31:0]             dc_addr_i,
    input logic                    dc_addr_ok_i,
    input logic [1:0]              mem_valid_i
);

    logic mem_pair;
    int   fail_count = 0;

    // both lanes carrying a cache access
    assign mem_pair = ex_valid_i[0] && ex_valid_i[1] &&
                      (ex_op_i[0] inside {exec_pkg::LD_W, exec_pkg::ST_W, exec_pkg::ST_B}) &&
                      (ex_op_i[1] inside {exec_pkg::LD_W, exec_pkg::ST_W, exec_pkg::ST_B});

    reset_clears_mem: assert property (@(posedge clk) !rst_n_i |=> mem_valid_i == 2'b00)
        else begin
            fail_count++;
            $error("memory register still valid after reset");
        end

    one_mem_op: assert property (@(posedge clk) disable iff (!rst_n_i) !mem_pair)
        else begin
            fail_count++;
            $error("two memory ops issued in one lane pair");
        end

    // a stalled request waits at the port unchanged
    stall_holds_request: assert property (@(posedge clk) disable iff (!rst_n_i)
        pause_ex_i |=> dc_valid_i && $stable(dc_addr_i))
        else begin
            fail_count++;
            $error("cache request dropped or changed while stalled");
        end

    // held pair must not send its request twice
    accepted_not_resent: assert property (@(posedge clk) disable iff (!rst_n_i)
        dc_valid_i && dc_addr_ok_i && pause_i |=> !dc_valid_i)
        else begin
            fail_count++;
            $error("accepted cache request sent again while the pair was held");
        end

    stall_inserts_bubble: assert property (@(posedge clk) disable iff (!rst_n_i)
        pause_ex_i |=> mem_valid_i == 2'b00)
        else begin
            fail_count++;
            $error("memory register loaded during a stall");
        end

endmodule

bind dual_execute exec_sva u_sva (
    .clk         (clk),
    .rst_n_i     (rst_n_i),
    .ex_valid_i  (ex_valid_i),
    .ex_op_i     (ex_op_i),
    .pause_i     (pause_i),
    .pause_ex_i  (pause_ex_o),
    .dc_valid_i  (dc_valid_o),
    .dc_addr_i   (dc_addr_o),
    .dc_addr_ok_i(dc_addr_ok_i),
    .mem_valid_i (mem_valid_o)
);

// ==== testbench/tb_dual_execute.sv ====
`timescale 1ns/100ps

module tb_dual_execute;

    localparam int          NUM_TESTS       = 400;
    localparam int          CYCLES_PER_TEST = 20;
    localparam logic [31:0] SEED            = 32'hacad9933;

    logic                    clk = 1'b0;
    logic                    rst_n_i;
    logic [1:0]              ex_valid_i;
    exec_pkg::alu_op_e [1:0] ex_op_i;
    logic [1:0][31:0]        ex_pc_i;
    logic [1:0][31:0]        ex_src1_i;
    logic [1:0][31:0]        ex_src2_i;
    logic [1:0][31:0]        ex_imm_i;
    logic [1:0][4:0]         ex_rd_i;
    logic [1:0]              ex_wen_i;
    logic                    flush_i;
    logic                    pause_i;
    logic                    dc_valid_o;
    logic                    dc_we_o;
    logic [31:0]             dc_addr_o;
    logic [31:0]             dc_wdata_o;
    logic [3:0]              dc_wstrb_o;
    logic                    dc_addr_ok_i;
    logic                    pause_ex_o;
    logic                    branch_flush_o;
    logic [31:0]             branch_target_o;
    logic [1:0]              fwd_wen_o;
    logic [1:0][4:0]         fwd_rd_o;
    logic [1:0][31:0]        fwd_data_o;
    logic [1:0]              mem_valid_o;
    exec_pkg::alu_op_e [1:0] mem_op_o;
    logic [1:0][4:0]         mem_rd_o;
    logic [1:0]              mem_wen_o;
    logic [1:0][31:0]        mem_result_o;
    logic [1:0][31:0]        mem_addr_o;
    int                      err_count_o;
    int                      chk_count_o;

    logic [31:0] lfsr     = SEED;
    logic [31:0] next_pc  = 32'h1c00_0000;
    logic        consumed = 1'b0;
    int          issued   = 0;

    always #5 clk = ~clk;

    dual_execute dut0 (.*);

    exec_checker chk0 (.*);

    // pair in execute moves on when neither pause is up
    always @(posedge clk) begin
        consumed <= rst_n_i && !pause_ex_o && !pause_i;
    end

    // taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int k = 0; k < n; k++) begin
            lfsr = lfsr_next(lfsr);
            v = {v[30:0], lfsr[0]};
        end
    endtask

    task automatic issue_pair();
        logic [31:0] r;
        for (int i = 0; i < 2; i++) begin
            take_bits(5, r);
            ex_op_i[i] = exec_pkg::alu_op_e'(r[4:0] % 5'd22);
            take_bits(3, r);
            ex_valid_i[i] = (r[2:0] != 3'd0);
            take_bits(32, r);
            ex_src1_i[i] = r;
            take_bits(2, r);
            // equal operands now and then so compares see ties
            if (r[1:0] == 2'd0) begin
                ex_src2_i[i] = ex_src1_i[i];
            end else begin
                take_bits(32, r);
                ex_src2_i[i] = r;
            end
            take_bits(32, r);
            ex_imm_i[i] = r;
            take_bits(5, r);
            ex_rd_i[i] = r[4:0];
            take_bits(1, r);
            ex_wen_i[i] = r[0];
            ex_pc_i[i] = next_pc + 32'(4 * i);
        end
        next_pc = next_pc + 32'd8;
        // dispatch never pairs two cache accesses
        if ((ex_op_i[0] inside {exec_pkg::LD_W, exec_pkg::ST_W, exec_pkg::ST_B}) &&
            (ex_op_i[1] inside {exec_pkg::LD_W, exec_pkg::ST_W, exec_pkg::ST_B})) begin
            ex_op_i[1] = exec_pkg::ADD;
        end
    endtask

    initial begin
        logic [31:0] r;
        rst_n_i      = 1'b0;
        ex_valid_i   = '0;
        ex_op_i      = {exec_pkg::NOP, exec_pkg::NOP};
        ex_pc_i      = '0;
        ex_src1_i    = '0;
        ex_src2_i    = '0;
        ex_imm_i     = '0;
        ex_rd_i      = '0;
        ex_wen_i     = '0;
        flush_i      = 1'b0;
        pause_i      = 1'b0;
        dc_addr_ok_i = 1'b0;
        repeat (2) @(posedge clk);
        @(negedge clk);
        rst_n_i = 1'b1;
        while (issued < NUM_TESTS) begin
            @(negedge clk);
            if (consumed) begin
                issue_pair();
                issued++;
            end
            // cache model answers on about half the cycles
            take_bits(1, r);
            dc_addr_ok_i = r[0];
            take_bits(4, r);
            pause_i = (r[3:0] == 4'd0);
            take_bits(5, r);
            flush_i = (r[4:0] == 5'd0);
        end
        @(negedge clk);
        dc_addr_ok_i = 1'b1;
        pause_i      = 1'b0;
        flush_i      = 1'b0;
        repeat (3) @(negedge clk);
        $display("checks run %0d, errors %0d, assertion failures %0d",
                 chk_count_o, err_count_o, dut0.u_sva.fail_count);
        if (err_count_o == 0 && chk_count_o > 0 && dut0.u_sva.fail_count == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

    // watchdog
    initial begin
        repeat (NUM_TESTS * CYCLES_PER_TEST) @(posedge clk);
        $display("watchdog expired after %0d cycles with %0d pairs issued",
                 NUM_TESTS * CYCLES_PER_TEST, issued);
        $display("tests failed");
        $finish;
    end

endmodule
